// File: verilog.f
+incdir+dv
hdl/rvPkg.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/hazardUnit.sv
hdl/executeStage.sv
hdl/memStage.sv
hdl/rvCore.sv
dv/rvTb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = rvTb
FILELIST = verilog.f

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "RESULT: PASS" > /dev/null

clean:
	rm -rf obj_dir

// File: dv/rvModel.svh
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

logic [31:0] mRegs [32];
logic [31:0] mMem [2**dmemAddrBits];
logic [31:0] expPrints [$];
logic        expHalt;

function automatic logic [31:0] aluModel(logic [2:0] f3, logic alt, logic [31:0] a,
                                         logic [31:0] b);
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return {31'b0, $signed(a) < $signed(b)};
        3'd3: return {31'b0, a < b};
        3'd4: return a ^ b;
        3'd5: begin
            if (alt) return $signed(a) >>> b[4:0];
            return a >> b[4:0];
        end
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic brModel(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    case (f3)
        3'd0: return a == b;
        3'd1: return a != b;
        3'd4: return $signed(a) < $signed(b);
        3'd5: return $signed(a) >= $signed(b);
        3'd6: return a < b;
        3'd7: return a >= b;
        default: return 1'b0;
    endcase
endfunction

// runs prog one instruction at a time, collecting prints until the halt ecall
task automatic runModel();
    logic [31:0] pc;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [31:0] iImm;
    logic [31:0] addr;
    logic [31:0] nextPc;
    logic        wr;
    int          steps;
    for (int i = 0; i < 32; i++) mRegs[i] = '0;
    for (int i = 0; i < 2**dmemAddrBits; i++) mMem[i] = '0;
    expPrints.delete();
    expHalt = 1'b0;
    pc = '0;
    steps = 0;
    while (!expHalt && steps < 1000) begin
        w = prog[pc[7:2]];                  // 64-word program
        a = mRegs[w[19:15]];
        b = mRegs[w[24:20]];
        iImm = {{20{w[31]}}, w[31:20]};
        nextPc = pc + 32'd4;
        wr = 1'b1;
        r = '0;
        case (w[6:0])
            7'h37: r = {w[31:12], 12'b0};
            7'h17: r = pc + {w[31:12], 12'b0};
            7'h6f: begin
                r = pc + 32'd4;
                nextPc = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            7'h67: begin
                r = pc + 32'd4;
                nextPc = (a + iImm) & ~32'd1;
            end
            7'h63: begin
                wr = 1'b0;
                if (brModel(w[14:12], a, b))
                    nextPc = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            7'h03: begin
                addr = a + iImm;
                r = mMem[addr[dmemAddrBits+1:2]];
            end
            7'h23: begin
                wr = 1'b0;
                addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                mMem[addr[dmemAddrBits+1:2]] = b;
            end
            7'h13: r = aluModel(w[14:12], w[30] && w[14:12] == 3'd5, a, iImm);
            7'h33: r = aluModel(w[14:12], w[30], a, b);
            7'h73: begin
                wr = 1'b0;
                if (mRegs[17] == 32'd34) expPrints.push_back(mRegs[10]);   // a7 = 34 prints a0
                else expHalt = 1'b1;
            end
            default: wr = 1'b0;
        endcase
        if (wr && w[11:7] != 5'd0) mRegs[w[11:7]] = r;
        pc = nextPc;
        steps++;
    end
endtask

`endif

// File: dv/rvTb.sv
module rvTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int imemAddrBits  = 8;
    localparam int dmemAddrBits  = 6;
    localparam int progWords     = 64;     // 60 instructions and nop padding
    localparam int haltAt        = 58;     // halt sequence sits in slots 58 and 59
    localparam int numProgs      = 10;
    localparam int timeoutCycles = 2000;

    logic                    clk;
    logic                    rstN;
    logic                    progWe;
    logic [imemAddrBits-1:0] progAddr;
    logic [31:0]             progData;
    logic [31:0]             ledData;
    logic                    ledValid;
    logic                    halted;

    logic [31:0] prog [progWords];
    integer      seed;
    int          lastRd;

    `include "rvModel.svh"

    rvCore #(.imemAddrBits(imemAddrBits), .dmemAddrBits(dmemAddrBits)) uut (
        .clk(clk), .rstN(rstN),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .ledData(ledData), .ledValid(ledValid), .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abortRun(string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "stopping at the first error");
    endtask

    function automatic int randBelow(int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fffffff) % n;
    endfunction

    // a0 is favoured so prints carry fresh values
    function automatic logic [4:0] pickRd();
        logic [4:0] rd;
        rd = (randBelow(4) == 0) ? 5'd10 : 5'(randBelow(15) + 1);
        lastRd = int'(rd);
        return rd;
    endfunction

    function automatic logic [4:0] pickSrc();
        if (randBelow(2) == 0) return 5'(lastRd);    // back-to-back dependency
        return 5'(randBelow(16));
    endfunction

    function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    task automatic genProgram();
        int          i;
        int          kind;
        int          k;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rsA;
        logic [4:0]  rsB;
        logic        alt;
        logic [11:0] imm12;
        logic [11:0] memOff;
        logic [19:0] uImm;
        logic [12:0] bOff;
        logic [20:0] jOff;
        for (int j = 0; j < progWords; j++) prog[j] = 32'h00000013;
        prog[0] = encI(12'd34, 5'd0, 3'd0, 5'd17, 7'h13);    // a7 stays 34 until the halt
        lastRd = 10;
        i = 1;
        while (i < haltAt) begin
            kind = randBelow(16);
            if (kind >= 13 && i + 5 > haltAt) kind = 0;      // keep targets inside the program
            k = 2 + randBelow(4);
            f3 = 3'(randBelow(8));
            rsA = pickSrc();
            rsB = pickSrc();
            imm12 = 12'(randBelow(4096));
            memOff = 12'(4 * randBelow(2**dmemAddrBits));
            uImm = 20'(randBelow(1048576));
            case (kind)
                6, 7, 8, 9: begin
                    rd = pickRd();
                    alt = (f3 == 3'd0 || f3 == 3'd5) && randBelow(2) == 1;
                    prog[i] = {1'b0, alt, 5'b0, rsB, rsA, f3, rd, 7'h33};
                end
                10: begin
                    rd = pickRd();
                    prog[i] = {uImm, rd, f3[0] ? 7'h17 : 7'h37};
                end
                11: prog[i] = encI(memOff, 5'd0, 3'd2, pickRd(), 7'h03);
                12: prog[i] = {memOff[11:5], rsB, 5'd0, 3'd2, memOff[4:0], 7'h23};
                13: begin
                    if (f3 == 3'd2 || f3 == 3'd3) f3 = 3'd0;
                    bOff = 13'(4 * k);
                    prog[i] = {bOff[12], bOff[10:5], rsB, rsA, f3, bOff[4:1], bOff[11], 7'h63};
                end
                14: begin
                    rd = pickRd();
                    jOff = 21'(4 * k);
                    if (randBelow(2) == 0)
                        prog[i] = {jOff[20], jOff[10:1], jOff[11], jOff[19:12], rd, 7'h6f};
                    else
                        prog[i] = encI(12'(4 * (i + k)), 5'd0, 3'd0, rd, 7'h67);  // absolute
                end
                15: begin
                    prog[i] = encI(12'd34, 5'd0, 3'd0, 5'd17, 7'h13);
                    prog[i + 1] = 32'h00000073;
                    i++;
                end
                default: begin
                    rd = pickRd();
                    if (f3 == 3'd1) imm12 = {7'b0, imm12[4:0]};
                    if (f3 == 3'd5) imm12 = {1'b0, imm12[11], 5'b0, imm12[4:0]};   // srli or srai
                    prog[i] = encI(imm12, rsA, f3, rd, 7'h13);
                end
            endcase
            i++;
        end
        prog[haltAt] = encI(12'd10, 5'd0, 3'd0, 5'd17, 7'h13);
        prog[haltAt + 1] = 32'h00000073;
    endtask

    // program port only works while reset is held, so reset spans the load plus 16 cycles
    task automatic loadProgram();
        rstN = 1'b0;
        for (int addr = 0; addr < progWords; addr++) begin
            @(posedge clk);
            #1;
            progWe   = 1'b1;
            progAddr = imemAddrBits'(addr);
            progData = prog[addr];
        end
        @(posedge clk);
        #1;
        progWe = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        assert (!ledValid && !halted) else abortRun("ledValid or halted is high during reset");
        rstN = 1'b1;
    endtask

    task automatic checkRun(int progNum);
        int cycles;
        int printIdx;
        cycles = 0;
        printIdx = 0;
        while (!halted) begin
            @(posedge clk);
            #1;
            cycles++;
            assert (cycles <= timeoutCycles)
                else abortRun($sformatf("core never halted in program %0d", progNum));
            if (ledValid) begin
                assert (printIdx < expPrints.size())
                    else abortRun($sformatf("unexpected print of %h in program %0d",
                                            ledData, progNum));
                assert (ledData == expPrints[printIdx])
                    else abortRun($sformatf("FAIL ledData expected %h actual %h",
                                            expPrints[printIdx], ledData));
                printIdx++;
            end
        end
        assert (printIdx == expPrints.size())
            else abortRun($sformatf("FAIL print count expected %h actual %h",
                                    expPrints.size(), printIdx));
        repeat (8) begin
            @(posedge clk);
            #1;
            assert (halted && !ledValid)
                else abortRun("halted dropped or ledValid strobed after the halt");
        end
    endtask

    initial begin
        seed     = 96;
        rstN     = 1'b0;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        for (int p = 0; p < numProgs; p++) begin
            genProgram();
            runModel();
            assert (expHalt) else abortRun("reference model never reached the halt ecall");
            loadProgram();
            checkRun(p);
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: hdl/rvCore.sv
module rvCore #(
    parameter int imemAddrBits = 8,
    parameter int dmemAddrBits = 6
) (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    progWe,
    input  logic [imemAddrBits-1:0] progAddr,
    input  rvPkg::instrT            progData,
    output logic [31:0]             ledData,
    output logic                    ledValid,
    output logic                    halted
);
    import rvPkg::*;

    ifIdT        ifId;
    idExT        idEx;
    exMemT       exMem;
    memWbT       memWb;
    regIdxT      rs1;
    regIdxT      rs2;
    logic        stall;
    logic        flush;
    logic        redirect;
    logic [31:0] redirectPc;
    fwdSelT      fwdA;
    fwdSelT      fwdB;

    fetchStage #(.imemAddrBits(imemAddrBits)) fetch (
        .clk(clk), .rstN(rstN),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .stall(stall), .redirect(redirect), .redirectPc(redirectPc), .halted(halted),
        .ifId(ifId)
    );

    decodeStage decode (
        .clk(clk), .rstN(rstN),
        .ifId(ifId), .memWb(memWb),
        .stall(stall), .flush(flush), .halted(halted),
        .idEx(idEx), .rs1(rs1), .rs2(rs2)
    );

    hazardUnit hazard (
        .idEx(idEx), .exMem(exMem), .rs1(rs1), .rs2(rs2), .redirect(redirect),
        .stall(stall), .flush(flush), .fwdA(fwdA), .fwdB(fwdB)
    );

    executeStage execute (
        .clk(clk), .rstN(rstN),
        .idEx(idEx), .memWb(memWb), .fwdA(fwdA), .fwdB(fwdB), .halted(halted),
        .exMem(exMem), .redirect(redirect), .redirectPc(redirectPc)
    );

    memStage #(.dmemAddrBits(dmemAddrBits)) mem (
        .clk(clk), .rstN(rstN),
        .exMem(exMem),
        .memWb(memWb), .ledData(ledData), .ledValid(ledValid), .halted(halted)
    );

endmodule

// File: hdl/memStage.sv
module memStage #(
    parameter int dmemAddrBits = 6
) (
    input  logic          clk,
    input  logic          rstN,
    input  rvPkg::exMemT  exMem,
    output rvPkg::memWbT  memWb,
    output logic [31:0]   ledData,
    output logic          ledValid,
    output logic          halted
);
    import rvPkg::*;

    logic [31:0]             dmem [2**dmemAddrBits];
    logic [dmemAddrBits-1:0] addr;
    logic                    printNow;

    assign addr = exMem.result[dmemAddrBits+1:2];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 2**dmemAddrBits; i++) dmem[i] <= '0;
        end else if (exMem.ctrl.memWrite && !halted) begin
            dmem[addr] <= exMem.storeData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memWb <= '0;
        end else if (!halted) begin
            memWb <= '{regWrite: exMem.ctrl.regWrite, memToReg: exMem.ctrl.memToReg,
                       ecall: exMem.ctrl.ecall, aluResult: exMem.result,
                       loadData: dmem[addr], a0Val: exMem.result,
                       a7Val: exMem.storeData, rd: exMem.rd};
        end
    end

    // ecall acts in writeback, so everything older has already retired
    assign printNow = memWb.ecall && memWb.a7Val == ecallPrint;
    // the frozen memWb keeps the halting ecall, so halted stays up until reset
    assign halted   = memWb.ecall && memWb.a7Val != ecallPrint;   // freezes the pipe at once

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ledValid <= 1'b0;
        end else begin
            ledValid <= printNow;
        end
    end

    always_ff @(posedge clk) begin
        if (printNow) ledData <= memWb.a0Val;
    end

    assert property (@(posedge clk) disable iff (!rstN)
        (exMem.ctrl.memWrite || exMem.ctrl.memToReg) |-> exMem.result[1:0] == 2'b00)
        else $error("misaligned word access at %h", exMem.result);

endmodule

// File: hdl/executeStage.sv
module executeStage (
    input  logic          clk,
    input  logic          rstN,
    input  rvPkg::idExT   idEx,
    input  rvPkg::memWbT  memWb,
    input  rvPkg::fwdSelT fwdA,
    input  rvPkg::fwdSelT fwdB,
    input  logic          halted,
    output rvPkg::exMemT  exMem,
    output logic          redirect,
    output logic [31:0]   redirectPc
);
    import rvPkg::*;

    logic [31:0] valA;
    logic [31:0] valB;
    logic [31:0] opB;
    logic [31:0] aluY;
    logic [31:0] target;
    logic [31:0] result;
    logic        taken;

    function automatic logic [31:0] pick(fwdSelT sel, regIdxT idx, logic [31:0] regVal,
                                         exMemT mem, memWbT wb);
        case (sel)
            fwdMem:  return mem.result;
            fwdWb:   return (wb.regWrite && wb.rd == idx) ? wbValue(wb) : regVal;
            default: return regVal;
        endcase
    endfunction

    assign valA = pick(fwdA, idEx.rs1, idEx.rs1Val, exMem, memWb);
    assign valB = pick(fwdB, idEx.rs2, idEx.rs2Val, exMem, memWb);
    assign opB  = idEx.ctrl.aluSrcImm ? idEx.imm : valB;

    always_comb begin
        case (idEx.ctrl.aluOp)
            aluSub:  aluY = valA - opB;
            aluSlt:  aluY = {31'b0, $signed(valA) < $signed(opB)};
            aluSltu: aluY = {31'b0, valA < opB};
            aluXor:  aluY = valA ^ opB;
            aluOr:   aluY = valA | opB;
            aluAnd:  aluY = valA & opB;
            aluSll:  aluY = valA << opB[4:0];
            aluSrl:  aluY = valA >> opB[4:0];
            aluSra:  aluY = $signed(valA) >>> opB[4:0];
            default: aluY = valA + opB;
        endcase
    end

    always_comb begin
        case (idEx.ctrl.brKind)
            brEq:    taken = valA == valB;
            brNe:    taken = valA != valB;
            brLt:    taken = $signed(valA) < $signed(valB);
            brGe:    taken = $signed(valA) >= $signed(valB);
            brLtu:   taken = valA < valB;
            brGeu:   taken = valA >= valB;
            default: taken = 1'b0;
        endcase
    end

    assign target     = idEx.pc + idEx.imm;      // jal, branches and auipc
    assign redirect   = taken || idEx.ctrl.jal || idEx.ctrl.jalr;
    assign redirectPc = idEx.ctrl.jalr ? {aluY[31:1], 1'b0} : target;

    always_comb begin
        if (idEx.ctrl.lui) result = idEx.imm;
        else if (idEx.ctrl.auipc) result = target;
        else if (idEx.ctrl.jal || idEx.ctrl.jalr) result = idEx.pc + 32'd4;   // link
        else result = aluY;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exMem <= '0;
        end else if (!halted) begin
            exMem <= '{ctrl: idEx.ctrl, result: result, storeData: valB, rd: idEx.rd};
        end
    end

endmodule

// File: hdl/hazardUnit.sv
module hazardUnit (
    input  rvPkg::idExT   idEx,
    input  rvPkg::exMemT  exMem,
    input  rvPkg::regIdxT rs1,
    input  rvPkg::regIdxT rs2,
    input  logic          redirect,
    output logic          stall,
    output logic          flush,
    output rvPkg::fwdSelT fwdA,
    output rvPkg::fwdSelT fwdB
);
    import rvPkg::*;

    // fwdWb leaves the rd check in writeback to execute
    function automatic fwdSelT selFor(regIdxT src, exMemT mem);
        if (src == '0) return fwdNone;
        if (mem.ctrl.regWrite && mem.rd == src) return fwdMem;
        return fwdWb;
    endfunction

    assign fwdA = selFor(idEx.rs1, exMem);
    assign fwdB = selFor(idEx.rs2, exMem);

    // load result arrives a cycle too late for the instruction behind it
    assign stall = idEx.ctrl.memToReg && idEx.rd != '0 && (idEx.rd == rs1 || idEx.rd == rs2);
    assign flush = redirect;

    always_comb begin
        assert final (!(stall && redirect) && !(redirect && idEx.ctrl == '0))
            else $error("redirect raised by a bubble or together with a stall");
    end

endmodule

// File: hdl/decodeStage.sv
module decodeStage (
    input  logic          clk,
    input  logic          rstN,
    input  rvPkg::ifIdT   ifId,
    input  rvPkg::memWbT  memWb,
    input  logic          stall,
    input  logic          flush,
    input  logic          halted,
    output rvPkg::idExT   idEx,
    output rvPkg::regIdxT rs1,
    output rvPkg::regIdxT rs2
);
    import rvPkg::*;

    instrT       ir;
    ctrlT        ctrl;
    logic [31:0] imm;
    logic [31:0] iImm;
    logic [31:0] sImm;
    logic [31:0] bImm;
    logic [31:0] uImm;
    logic [31:0] jImm;
    logic [31:0] rs1Val;
    logic [31:0] rs2Val;
    logic [31:0] wbData;
    logic [31:0] regs [32];

    function automatic aluOpT aluFor(logic [2:0] funct3, logic alt);
        case (funct3)
            3'b000:  return alt ? aluSub : aluAdd;
            3'b001:  return aluSll;
            3'b010:  return aluSlt;
            3'b011:  return aluSltu;
            3'b100:  return aluXor;
            3'b101:  return alt ? aluSra : aluSrl;
            3'b110:  return aluOr;
            default: return aluAnd;
        endcase
    endfunction

    function automatic brKindT brFor(logic [2:0] funct3);
        case (funct3)
            3'b000:  return brEq;
            3'b001:  return brNe;
            3'b100:  return brLt;
            3'b101:  return brGe;
            3'b110:  return brLtu;
            3'b111:  return brGeu;
            default: return brNone;
        endcase
    endfunction

    assign ir   = ifId.instr;
    assign iImm = {{20{ir.iType.imm[11]}}, ir.iType.imm};
    assign sImm = {{20{ir.sType.immHi[6]}}, ir.sType.immHi, ir.sType.immLo};
    assign bImm = {{20{ir.bType.imm12}}, ir.bType.imm11, ir.bType.immHi, ir.bType.immLo, 1'b0};
    assign uImm = {ir.uType.imm, 12'b0};
    assign jImm = {{12{ir.jType.imm20}}, ir.jType.immHi, ir.jType.imm11, ir.jType.immLo, 1'b0};

    always_comb begin
        ctrl = '0;
        imm  = iImm;
        case (ir.rType.opcode)
            opLui: begin
                ctrl.regWrite = 1'b1;
                ctrl.lui      = 1'b1;
                imm = uImm;
            end
            opAuipc: begin
                ctrl.regWrite = 1'b1;
                ctrl.auipc    = 1'b1;
                imm = uImm;
            end
            opJal: begin
                ctrl.regWrite = 1'b1;
                ctrl.jal      = 1'b1;
                imm = jImm;
            end
            opJalr: begin
                ctrl.regWrite  = 1'b1;
                ctrl.jalr      = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opBranch: begin
                ctrl.brKind = brFor(ir.bType.funct3);
                imm = bImm;
            end
            opLoad: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opStore: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                imm = sImm;
            end
            opOpImm: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                // bit 30 only selects sra on the immediate form
                ctrl.aluOp = aluFor(ir.iType.funct3,
                                    ir.rType.funct7[5] && ir.iType.funct3 == 3'b101);
            end
            opOp: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluFor(ir.rType.funct3, ir.rType.funct7[5]);
            end
            opSystem: begin
                ctrl.ecall     = 1'b1;
                ctrl.aluSrcImm = 1'b1;      // a0 + 0 rides in the result field
                imm = '0;
            end
            default: ;
        endcase
    end

    // ecall reads a0 and a7 in place of its operand fields
    assign rs1 = !ifId.valid ? '0 : ctrl.ecall ? regA0 : ir.rType.rs1;
    assign rs2 = !ifId.valid ? '0 : ctrl.ecall ? regA7 : ir.rType.rs2;

    assign wbData = wbValue(memWb);
    assign rs1Val = (rs1 == '0) ? '0 :
                    (memWb.regWrite && memWb.rd == rs1) ? wbData : regs[rs1];
    assign rs2Val = (rs2 == '0) ? '0 :
                    (memWb.regWrite && memWb.rd == rs2) ? wbData : regs[rs2];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) regs[i] <= '0;
        end else if (memWb.regWrite && memWb.rd != '0) begin
            regs[memWb.rd] <= wbData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            idEx <= '0;
        end else if (!halted) begin
            if (flush || stall || !ifId.valid) idEx <= '0;    // bubble
            else idEx <= '{ctrl: ctrl, pc: ifId.pc, rs1Val: rs1Val, rs2Val: rs2Val,
                           imm: imm, rs1: rs1, rs2: rs2, rd: ir.rType.rd};
        end
    end

    // a valid entry always carries an opcode of the supported subset
    assert property (@(posedge clk) disable iff (!rstN)
        ifId.valid |-> ir.rType.opcode inside {opLui, opAuipc, opJal, opJalr, opBranch,
                                               opLoad, opStore, opOpImm, opOp, opSystem})
        else $error("unknown opcode %h in decode", ir.rType.opcode);

endmodule

// File: hdl/fetchStage.sv
module fetchStage #(
    parameter int imemAddrBits = 8
) (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    progWe,
    input  logic [imemAddrBits-1:0] progAddr,
    input  rvPkg::instrT            progData,
    input  logic                    stall,
    input  logic                    redirect,
    input  logic [31:0]             redirectPc,
    input  logic                    halted,
    output rvPkg::ifIdT             ifId
);
    import rvPkg::*;

    instrT       imem [2**imemAddrBits];
    logic [31:0] pc;

    // program port, only used while the core sits in reset
    always_ff @(posedge clk) begin
        if (progWe) imem[progAddr] <= progData;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc   <= '0;
            ifId <= '0;
        end else if (!halted) begin
            if (redirect) begin
                pc   <= redirectPc;
                ifId <= '0;                 // wrong-path fetch dropped
            end else if (!stall) begin
                pc   <= pc + 32'd4;
                ifId <= '{valid: 1'b1, pc: pc, instr: imem[pc[imemAddrBits+1:2]]};
            end
        end
    end

    assert property (@(posedge clk) !(progWe && rstN))
        else $error("program write while core is running");

endmodule

// File: hdl/rvPkg.sv
package rvPkg;

    typedef enum logic [6:0] {
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opOpImm  = 7'b0010011,
        opOp     = 7'b0110011,
        opSystem = 7'b1110011
    } opcodeT;

    typedef logic [4:0] regIdxT;

    typedef struct packed {
        logic [6:0] funct7;
        regIdxT     rs2;
        regIdxT     rs1;
        logic [2:0] funct3;
        regIdxT     rd;
        logic [6:0] opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm;
        regIdxT      rs1;
        logic [2:0]  funct3;
        regIdxT      rd;
        logic [6:0]  opcode;
    } iTypeT;

    typedef struct packed {
        logic [6:0] immHi;
        regIdxT     rs2;
        regIdxT     rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sTypeT;

    typedef struct packed {
        logic       imm12;
        logic [5:0] immHi;     // imm[10:5]
        regIdxT     rs2;
        regIdxT     rs1;
        logic [2:0] funct3;
        logic [3:0] immLo;     // imm[4:1]
        logic       imm11;
        logic [6:0] opcode;
    } bTypeT;

    typedef struct packed {
        logic [19:0] imm;
        regIdxT      rd;
        logic [6:0]  opcode;
    } uTypeT;

    typedef struct packed {
        logic       imm20;
        logic [9:0] immLo;     // imm[10:1]
        logic       imm11;
        logic [7:0] immHi;     // imm[19:12]
        regIdxT     rd;
        logic [6:0] opcode;
    } jTypeT;

    // one instruction word, viewed through each base format
    typedef union packed {
        rTypeT rType;
        iTypeT iType;
        sTypeT sType;
        bTypeT bType;
        uTypeT uType;
        jTypeT jType;
    } instrT;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSlt, aluSltu, aluXor, aluOr, aluAnd, aluSll, aluSrl, aluSra
    } aluOpT;

    typedef enum logic [2:0] {
        brNone, brEq, brNe, brLt, brGe, brLtu, brGeu
    } brKindT;

    typedef enum logic [1:0] {
        fwdNone, fwdMem, fwdWb
    } fwdSelT;

    typedef struct packed {
        logic   regWrite;
        logic   memToReg;
        logic   memWrite;
        logic   aluSrcImm;
        aluOpT  aluOp;
        brKindT brKind;
        logic   jal;
        logic   jalr;
        logic   lui;
        logic   auipc;
        logic   ecall;
    } ctrlT;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        instrT       instr;
    } ifIdT;

    typedef struct packed {
        ctrlT        ctrl;
        logic [31:0] pc;
        logic [31:0] rs1Val;
        logic [31:0] rs2Val;
        logic [31:0] imm;
        regIdxT      rs1;
        regIdxT      rs2;
        regIdxT      rd;
    } idExT;

    typedef struct packed {
        ctrlT        ctrl;
        logic [31:0] result;
        logic [31:0] storeData;   // a7 for an ecall
        regIdxT      rd;
    } exMemT;

    typedef struct packed {
        logic        regWrite;
        logic        memToReg;
        logic        ecall;
        logic [31:0] aluResult;
        logic [31:0] loadData;
        logic [31:0] a0Val;
        logic [31:0] a7Val;
        regIdxT      rd;
    } memWbT;

    localparam regIdxT      regA0      = 5'd10;
    localparam regIdxT      regA7      = 5'd17;
    localparam logic [31:0] ecallPrint = 32'd34;

    // value written back, also the writeback forwarding source
    function automatic logic [31:0] wbValue(memWbT wb);
        return wb.memToReg ? wb.loadData : wb.aluResult;
    endfunction

endpackage
